// ==== src/mul_cfg_pkg.sv ====
/*
 * Datapath widths and lane-shape/signedness encodings for the SIMD multiply unit.
 * Referenced by scoped names from the RTL and the op package.
 */
package mul_cfg_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int DATA_W = 64;        // Operand width.
    localparam int PROD_W = 2 * DATA_W; // Full product width.
    localparam int TAG_W  = 4;         // Request tag.

    // ==============================
    // Lane shape
    // ==============================
    // One 64-bit lane, two 32-bit lanes or four 16-bit lanes.
    typedef enum logic [1:0] {
        LANE_64 = 2'b00,
        LANE_32 = 2'b01,
        LANE_16 = 2'b10
    } lane_mode_e;

    // ==============================
    // Signedness
    // ==============================
    // Bit 1 marks operand a as signed, bit 0 marks operand b.
    typedef enum logic [1:0] {
        SIGN_UU = 2'b00,
        SIGN_US = 2'b01,
        SIGN_SU = 2'b10,
        SIGN_SS = 2'b11
    } sign_mode_e;

endpackage

// ==== src/mul_op_pkg.sv ====
/*
 * Result-select opcode and the request/response structs of the multiply unit.
 * Depends on mul_cfg_pkg, so it compiles after it.
 */
package mul_op_pkg;

    // ==============================
    // Result select
    // ==============================
    typedef enum logic [1:0] {
        SEL_WIDE = 2'b00,  // Full double-width products.
        SEL_LO   = 2'b01,  // Low half of each lane, packed.
        SEL_HI   = 2'b10   // High half of each lane, packed.
    } mul_sel_e;

    // ==============================
    // Request
    // ==============================
    // Sampled by the unit while in_valid is high.
    typedef struct packed {
        mul_sel_e                        sel;
        mul_cfg_pkg::lane_mode_e         lane;
        mul_cfg_pkg::sign_mode_e         sign;
        logic [mul_cfg_pkg::DATA_W-1:0]  a;
        logic [mul_cfg_pkg::DATA_W-1:0]  b;
        logic [mul_cfg_pkg::TAG_W-1:0]   tag;
    } mul_req_t;

    // ==============================
    // Response
    // ==============================
    // Packed lane results occupy the low 64 bits.
    typedef struct packed {
        logic [mul_cfg_pkg::PROD_W-1:0]  result;
        logic [mul_cfg_pkg::TAG_W-1:0]   tag;
    } mul_rsp_t;

endpackage

// ==== src/mul16.sv ====
/*
 * Leaf 16x16 multiplier. Each operand may be treated as signed; the
 * magnitudes are multiplied and the sign restored on the product.
 */
`timescale 1ns/1ns

module mul16 (
    input  logic [15:0]             a,
    input  logic [15:0]             b,
    input  mul_cfg_pkg::sign_mode_e sign,
    output logic [31:0]             prod
);

    logic        a_neg;
    logic        b_neg;
    logic [15:0] mag_a;
    logic [15:0] mag_b;
    logic [31:0] prod_mag;

    assign a_neg = sign[1] && a[15];
    assign b_neg = sign[0] && b[15];

    assign mag_a = a_neg ? (~a + 16'd1) : a;
    assign mag_b = b_neg ? (~b + 16'd1) : b;

    assign prod_mag = 32'(mag_a) * 32'(mag_b);
    assign prod     = (a_neg ^ b_neg) ? (~prod_mag + 32'd1) : prod_mag; // Restore sign.

endmodule

// ==== src/mul32.sv ====
/*
 * 32x32 multiplier from four mul16 blocks and a carry-save row.
 * With split high it returns two independent 16x16 lane products instead.
 */
`timescale 1ns/1ns

module mul32 (
    input  logic [31:0]             a,
    input  logic [31:0]             b,
    input  logic                    split,
    input  mul_cfg_pkg::sign_mode_e sign32,
    input  mul_cfg_pkg::sign_mode_e sign16,
    output logic [63:0]             prod
);

    logic        a_neg;
    logic        b_neg;
    logic [31:0] mag_a;
    logic [31:0] mag_b;
    logic [31:0] p0;
    logic [31:0] p1;
    logic [31:0] p2;
    logic [31:0] p3;
    logic [15:0] sum0;
    logic [15:0] cry0;
    logic [15:0] sum1;
    logic [15:0] cry1;
    logic [46:0] cpa;
    logic [63:0] wide;

    // ==============================
    // 32-bit sign handling
    // ==============================
    assign a_neg = sign32[1] && a[31];
    assign b_neg = sign32[0] && b[31];
    assign mag_a = a_neg ? (~a + 32'd1) : a;
    assign mag_b = b_neg ? (~b + 32'd1) : b;

    // Partial products at weights 0, 16, 16 and 32.
    mul16 i_mul16_0 (.a(mag_a[15:0]),  .b(mag_b[15:0]),  .sign(sign16), .prod(p0));
    mul16 i_mul16_1 (.a(mag_a[31:16]), .b(mag_b[15:0]),  .sign(sign16), .prod(p1));
    mul16 i_mul16_2 (.a(mag_a[15:0]),  .b(mag_b[31:16]), .sign(sign16), .prod(p2));
    mul16 i_mul16_3 (.a(mag_a[31:16]), .b(mag_b[31:16]), .sign(sign16), .prod(p3));

    // ==============================
    // Carry-save row
    // ==============================
    // Columns 16..31.
    assign sum0 = p0[31:16] ^ p1[15:0] ^ p2[15:0];
    assign cry0 = (p0[31:16] & p1[15:0]) | (p0[31:16] & p2[15:0]) | (p1[15:0] & p2[15:0]);

    // Columns 32..47.
    assign sum1 = p1[31:16] ^ p2[31:16] ^ p3[15:0];
    assign cry1 = (p1[31:16] & p2[31:16]) | (p1[31:16] & p3[15:0]) | (p2[31:16] & p3[15:0]);

    // Final carry-propagate add from column 17 up.
    assign cpa  = {15'b0, cry1, cry0} + {p3[31:16], sum1, sum0[15:1]};
    assign wide = {cpa, sum0[0], p0[15:0]};

    // Lane split bypasses the combine and the 32-bit sign fix.
    always_comb begin
        if (split) begin
            prod = {p3, p0};
        end else if (a_neg ^ b_neg) begin
            prod = ~wide + 64'd1;
        end else begin
            prod = wide;
        end
    end

endmodule

// ==== src/mul64_simd.sv ====
/*
 * 64x64 SIMD multiplier from four mul32 blocks.
 * The lane shape selects one 64x64, two 32x32 or four 16x16 products;
 * the raw result layout follows the lane shape.
 */
`timescale 1ns/1ns

module mul64_simd (
    input  logic [mul_cfg_pkg::DATA_W-1:0] a,
    input  logic [mul_cfg_pkg::DATA_W-1:0] b,
    input  mul_cfg_pkg::lane_mode_e        lane,
    input  mul_cfg_pkg::sign_mode_e        sign,
    output logic [mul_cfg_pkg::PROD_W-1:0] prod
);

    localparam int HW = mul_cfg_pkg::DATA_W / 2;

    logic                            is_64;
    logic                            split16;
    mul_cfg_pkg::sign_mode_e         sign32;
    mul_cfg_pkg::sign_mode_e         sign16;
    logic                            a_neg;
    logic                            b_neg;
    logic [mul_cfg_pkg::DATA_W-1:0]  mag_a;
    logic [mul_cfg_pkg::DATA_W-1:0]  mag_b;
    logic [63:0]                     q0;
    logic [63:0]                     q1;
    logic [63:0]                     q2;
    logic [63:0]                     q3;
    logic [31:0]                     sum0;
    logic [31:0]                     cry0;
    logic [31:0]                     sum1;
    logic [31:0]                     cry1;
    logic [94:0]                     cpa;
    logic [mul_cfg_pkg::PROD_W-1:0]  wide;

    // ==============================
    // Lane and sign controls
    // ==============================
    assign is_64   = (lane == mul_cfg_pkg::LANE_64);
    assign split16 = (lane == mul_cfg_pkg::LANE_16);
    assign sign32  = (lane == mul_cfg_pkg::LANE_32) ? sign : mul_cfg_pkg::SIGN_UU;
    assign sign16  = split16 ? sign : mul_cfg_pkg::SIGN_UU;

    // Magnitudes only for the single 64-bit lane.
    assign a_neg = is_64 && sign[1] && a[mul_cfg_pkg::DATA_W-1];
    assign b_neg = is_64 && sign[0] && b[mul_cfg_pkg::DATA_W-1];
    assign mag_a = a_neg ? (~a + 64'd1) : a;
    assign mag_b = b_neg ? (~b + 64'd1) : b;

    // ==============================
    // Partial products
    // ==============================
    // Diagonals double as the SIMD lanes.
    mul32 i_mul32_0 (
        .a      (mag_a[HW-1:0]),
        .b      (mag_b[HW-1:0]),
        .split  (split16),
        .sign32 (sign32),
        .sign16 (sign16),
        .prod   (q0)
    );

    mul32 i_mul32_1 (
        .a      (mag_a[2*HW-1:HW]),
        .b      (mag_b[HW-1:0]),
        .split  (1'b0),
        .sign32 (mul_cfg_pkg::SIGN_UU),
        .sign16 (mul_cfg_pkg::SIGN_UU),
        .prod   (q1)
    );

    mul32 i_mul32_2 (
        .a      (mag_a[HW-1:0]),
        .b      (mag_b[2*HW-1:HW]),
        .split  (1'b0),
        .sign32 (mul_cfg_pkg::SIGN_UU),
        .sign16 (mul_cfg_pkg::SIGN_UU),
        .prod   (q2)
    );

    mul32 i_mul32_3 (
        .a      (mag_a[2*HW-1:HW]),
        .b      (mag_b[2*HW-1:HW]),
        .split  (split16),
        .sign32 (sign32),
        .sign16 (sign16),
        .prod   (q3)
    );

    // ==============================
    // Carry-save row and final add
    // ==============================
    assign sum0 = q0[63:32] ^ q1[31:0] ^ q2[31:0];
    assign cry0 = (q0[63:32] & q1[31:0]) | (q0[63:32] & q2[31:0]) | (q1[31:0] & q2[31:0]);

    assign sum1 = q1[63:32] ^ q2[63:32] ^ q3[31:0];
    assign cry1 = (q1[63:32] & q2[63:32]) | (q1[63:32] & q3[31:0]) | (q2[63:32] & q3[31:0]);

    assign cpa  = {31'b0, cry1, cry0} + {q3[63:32], sum1, sum0[31:1]};
    assign wide = {cpa, sum0[0], q0[31:0]};

    always_comb begin
        if (!is_64) begin
            prod = {q3, q0};              // Lane products as is.
        end else if (a_neg ^ b_neg) begin
            prod = ~wide + 128'd1;
        end else begin
            prod = wide;
        end
    end

endmodule

// ==== src/lane_pack.sv ====
/*
 * Result formatting. Passes the raw product for wide results, or packs
 * the low or high half of every lane densely into the low 64 bits.
 */
`timescale 1ns/1ns

module lane_pack (
    input  logic [mul_cfg_pkg::PROD_W-1:0] raw,
    input  mul_cfg_pkg::lane_mode_e        lane,
    input  mul_op_pkg::mul_sel_e           sel,
    output logic [mul_cfg_pkg::PROD_W-1:0] result
);

    localparam int HALF_W = mul_cfg_pkg::PROD_W / 2;

    logic [HALF_W-1:0] lo_half;
    logic [HALF_W-1:0] hi_half;

    // ==============================
    // Half extraction
    // ==============================
    always_comb begin
        lo_half = '0;
        hi_half = '0;
        case (lane)
            mul_cfg_pkg::LANE_32: begin
                for (int k = 0; k < 2; k++) begin
                    lo_half[32*k +: 32] = raw[64*k +: 32];
                    hi_half[32*k +: 32] = raw[64*k+32 +: 32];
                end
            end
            mul_cfg_pkg::LANE_16: begin
                for (int k = 0; k < 4; k++) begin
                    lo_half[16*k +: 16] = raw[32*k +: 16];
                    hi_half[16*k +: 16] = raw[32*k+16 +: 16];
                end
            end
            default: begin
                lo_half = raw[HALF_W-1:0];
                hi_half = raw[mul_cfg_pkg::PROD_W-1:HALF_W];
            end
        endcase
    end

    // Upper half is zero for packed results.
    always_comb begin
        case (sel)
            mul_op_pkg::SEL_LO: result = {{HALF_W{1'b0}}, lo_half};
            mul_op_pkg::SEL_HI: result = {{HALF_W{1'b0}}, hi_half};
            default:            result = raw;
        endcase
    end

endmodule

// ==== src/simd_mul_unit.sv ====
/*
 * Two-stage pipelined SIMD integer multiply unit.
 * A request is taken on every cycle with in_valid high; its response
 * appears with out_valid two clock edges later, tag unchanged.
 */
`timescale 1ns/1ns

module simd_mul_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  mul_op_pkg::mul_req_t  req,
    output logic                  out_valid,
    output mul_op_pkg::mul_rsp_t  rsp
);

    logic                            s1_valid;
    mul_op_pkg::mul_req_t            s1_req;
    logic [mul_cfg_pkg::PROD_W-1:0]  raw_prod;
    logic [mul_cfg_pkg::PROD_W-1:0]  packed_res;
    logic                            s2_valid;
    mul_op_pkg::mul_rsp_t            s2_rsp;

    // ==============================
    // Stage 1: request register
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_req <= req;
        end
    end

    // ==============================
    // Multiply and pack
    // ==============================
    mul64_simd i_mul64_simd (
        .a    (s1_req.a),
        .b    (s1_req.b),
        .lane (s1_req.lane),
        .sign (s1_req.sign),
        .prod (raw_prod)
    );

    lane_pack i_lane_pack (
        .raw    (raw_prod),
        .lane   (s1_req.lane),
        .sel    (s1_req.sel),
        .result (packed_res)
    );

    // ==============================
    // Stage 2: response register
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    // Tag follows its request.
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_rsp.result <= packed_res;
            s2_rsp.tag    <= s1_req.tag;
        end
    end

    assign out_valid = s2_valid;
    assign rsp       = s2_rsp;

endmodule

// ==== sim/tb_clock.sv ====
/*
 * Testbench clock and reset. 10 ns clock; rst_n is held low for the
 * first 16 rising edges and released 1 ns after the last one.
 */
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;  // Released off the edge.
    end

endmodule

// ==== sim/tb_simd_mul.sv ====
/*
 * Directed testbench for the SIMD multiply unit. Each test drives requests
 * 1 ns after the rising edge and checks every response against a per-lane
 * signed model of the product, packing and tag rules.
 */
`timescale 1ns/1ns

module tb_simd_mul;

    localparam int IDLE_CYCLES  = 8;
    localparam int STREAM_REQS  = 64;
    localparam int WIDE64_REQS  = 4 * (16 + 8);
    localparam int LANES_REQS   = 2 * 4 * 5;
    localparam int PACKED_REQS  = 2 * 3 * 4 * 3;
    localparam int MAX_CYCLES   = 16 + IDLE_CYCLES + 3 * (WIDE64_REQS + LANES_REQS + PACKED_REQS)
                                  + STREAM_REQS + 3 + 100;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    mul_op_pkg::mul_req_t  req;
    logic                  out_valid;
    mul_op_pkg::mul_rsp_t  rsp;
    logic [31:0]           lfsr;
    logic [3:0]            next_tag;

    tb_clock i_clock (.clk(clk), .rst_n(rst_n));

    simd_mul_unit i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .rsp       (rsp)
    );

    // ==============================
    // Failure reporting and checks
    // ==============================
    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopping on first failure");
    endtask

    task automatic check_result(input string name, input logic [mul_cfg_pkg::PROD_W-1:0] expected,
                                input logic [mul_cfg_pkg::PROD_W-1:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERR %s expected 0x%h got 0x%h", name, expected, actual));
        end
    endtask

    task automatic check_tag(input string name, input logic [mul_cfg_pkg::TAG_W-1:0] expected,
                             input logic [mul_cfg_pkg::TAG_W-1:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERR %s expected 0x%h got 0x%h", name, expected, actual));
        end
    endtask

    task automatic check_valid(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERR %s expected 0x%h got 0x%h", name, expected, actual));
        end
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                stop_with_failure("timeout: the run went past its cycle budget");
            end
        end
    end

    // ==============================
    // Stimulus and model
    // ==============================
    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // Product of the low w bits of each operand as a 2w-bit value.
    function automatic logic [127:0] lane_prod(input logic [63:0] op_a, input logic [63:0] op_b,
                                               input int w, input logic sa, input logic sb);
        logic [63:0]         mask;
        logic [63:0]         av;
        logic [63:0]         bv;
        logic signed [129:0] ea;
        logic signed [129:0] eb;
        logic signed [129:0] p;
        mask = (64'd1 << w) - 64'd1;
        av = op_a & mask;
        bv = op_b & mask;
        ea = $signed({66'd0, av});
        eb = $signed({66'd0, bv});
        if (sa && av[w-1]) ea = ea - (130'sd1 <<< w);
        if (sb && bv[w-1]) eb = eb - (130'sd1 <<< w);
        p = ea * eb;
        return p[127:0] & ((128'd1 << (2 * w)) - 128'd1);
    endfunction

    function automatic mul_op_pkg::mul_rsp_t model_rsp(input mul_op_pkg::mul_req_t r);
        mul_op_pkg::mul_rsp_t expected;
        logic [127:0]         raw;
        logic [127:0]         p;
        logic [63:0]          lo;
        logic [63:0]          hi;
        logic [63:0]          half_mask;
        int                   w;
        int                   k;
        case (r.lane)
            mul_cfg_pkg::LANE_32: w = 32;
            mul_cfg_pkg::LANE_16: w = 16;
            default:              w = 64;
        endcase
        raw = '0;
        lo = '0;
        hi = '0;
        half_mask = (64'd1 << w) - 64'd1;
        for (k = 0; k < 64 / w; k++) begin
            p = lane_prod(r.a >> (w * k), r.b >> (w * k), w, r.sign[1], r.sign[0]);
            raw = raw | (p << (2 * w * k));
            lo = lo | ((p[63:0] & half_mask) << (w * k));
            hi = hi | ((64'(p >> w) & half_mask) << (w * k));
        end
        case (r.sel)
            mul_op_pkg::SEL_LO: expected.result = {64'd0, lo};
            mul_op_pkg::SEL_HI: expected.result = {64'd0, hi};
            default:            expected.result = raw;
        endcase
        expected.tag = r.tag;
        return expected;
    endfunction

    function automatic mul_op_pkg::mul_req_t make_req(input mul_op_pkg::mul_sel_e sel,
                                                      input mul_cfg_pkg::lane_mode_e lane,
                                                      input mul_cfg_pkg::sign_mode_e sign,
                                                      input logic [63:0] a, input logic [63:0] b);
        mul_op_pkg::mul_req_t r;
        r.sel = sel;
        r.lane = lane;
        r.sign = sign;
        r.a = a;
        r.b = b;
        r.tag = '0;
        return r;
    endfunction

    // One isolated request; the response is due 2 edges after the drive.
    task automatic run_request(input mul_op_pkg::mul_req_t r_in);
        mul_op_pkg::mul_req_t r;
        mul_op_pkg::mul_rsp_t expected;
        r = r_in;
        r.tag = next_tag;
        next_tag = next_tag + 1'b1;
        expected = model_rsp(r);
        @(posedge clk);
        #1;
        req = r;
        in_valid = 1'b1;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        check_valid("out_valid", 1'b0, out_valid);
        @(posedge clk);
        #1;
        check_valid("out_valid", 1'b1, out_valid);
        check_result("rsp.result", expected.result, rsp.result);
        check_tag("rsp.tag", expected.tag, rsp.tag);
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic test_reset();
        int i;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            check_valid("out_valid", 1'b0, out_valid);
        end
        for (i = 0; i < IDLE_CYCLES; i++) begin
            @(negedge clk);
            check_valid("out_valid", 1'b0, out_valid);
        end
    endtask

    task automatic test_wide64();
        logic [63:0]             corner [4];
        logic [63:0]             a;
        logic [63:0]             b;
        mul_cfg_pkg::sign_mode_e sign;
        int                      s;
        int                      i;
        int                      j;
        corner[0] = 64'd0;
        corner[1] = 64'd1;
        corner[2] = '1;
        corner[3] = 64'h8000_0000_0000_0000;  // Most negative.
        for (s = 0; s < 4; s++) begin
            sign = mul_cfg_pkg::sign_mode_e'(s[1:0]);
            for (i = 0; i < 4; i++) begin
                for (j = 0; j < 4; j++) begin
                    run_request(make_req(mul_op_pkg::SEL_WIDE, mul_cfg_pkg::LANE_64, sign,
                                         corner[i], corner[j]));
                end
            end
            for (i = 0; i < 8; i++) begin
                a = rand_bits(64);
                b = rand_bits(64);
                run_request(make_req(mul_op_pkg::SEL_WIDE, mul_cfg_pkg::LANE_64, sign, a, b));
            end
        end
    endtask

    task automatic test_lanes_wide();
        logic [63:0]             a;
        logic [63:0]             b;
        mul_cfg_pkg::lane_mode_e lane;
        mul_cfg_pkg::sign_mode_e sign;
        int                      l;
        int                      s;
        int                      i;
        for (l = 0; l < 2; l++) begin
            lane = (l == 0) ? mul_cfg_pkg::LANE_32 : mul_cfg_pkg::LANE_16;
            for (s = 0; s < 4; s++) begin
                sign = mul_cfg_pkg::sign_mode_e'(s[1:0]);
                // Top bits set in several lanes.
                run_request(make_req(mul_op_pkg::SEL_WIDE, lane, sign,
                                     64'h8000_0001_ffff_8000, 64'hffff_8000_8000_7fff));
                for (i = 0; i < 4; i++) begin
                    a = rand_bits(64);
                    b = rand_bits(64);
                    run_request(make_req(mul_op_pkg::SEL_WIDE, lane, sign, a, b));
                end
            end
        end
    endtask

    task automatic test_packed();
        logic [63:0] a;
        logic [63:0] b;
        int          sl;
        int          l;
        int          s;
        int          i;
        for (sl = 1; sl < 3; sl++) begin
            for (l = 0; l < 3; l++) begin
                for (s = 0; s < 4; s++) begin
                    for (i = 0; i < 3; i++) begin
                        a = rand_bits(64);
                        b = rand_bits(64);
                        run_request(make_req(mul_op_pkg::mul_sel_e'(sl[1:0]),
                                             mul_cfg_pkg::lane_mode_e'(l[1:0]),
                                             mul_cfg_pkg::sign_mode_e'(s[1:0]), a, b));
                    end
                end
            end
        end
    endtask

    // Back-to-back requests; response i-2 is checked while request i goes in.
    task automatic test_stream();
        mul_op_pkg::mul_rsp_t pending [$];
        mul_op_pkg::mul_rsp_t expected;
        mul_op_pkg::mul_req_t r;
        logic [63:0]          bits;
        int                   i;
        for (i = 0; i < STREAM_REQS + 2; i++) begin
            @(posedge clk);
            #1;
            if (i >= 2) begin
                expected = pending.pop_front();
                check_valid("out_valid", 1'b1, out_valid);
                check_result("rsp.result", expected.result, rsp.result);
                check_tag("rsp.tag", expected.tag, rsp.tag);
            end else begin
                check_valid("out_valid", 1'b0, out_valid);
            end
            if (i < STREAM_REQS) begin
                bits = rand_bits(6);
                r.sel = mul_op_pkg::mul_sel_e'(bits[1:0] % 2'd3);
                r.lane = mul_cfg_pkg::lane_mode_e'(bits[3:2] % 2'd3);
                r.sign = mul_cfg_pkg::sign_mode_e'(bits[5:4]);
                r.a = rand_bits(64);
                r.b = rand_bits(64);
                r.tag = i[3:0];
                pending.push_back(model_rsp(r));
                req = r;
                in_valid = 1'b1;
            end else begin
                in_valid = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        check_valid("out_valid", 1'b0, out_valid);
    endtask

    initial begin
        in_valid = 1'b0;
        req = '0;
        lfsr = 32'h1cd3f850;
        next_tag = '0;
        test_reset();
        test_wide64();
        test_lanes_wide();
        test_packed();
        test_stream();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== files.f ====
src/mul_cfg_pkg.sv
src/mul_op_pkg.sv
src/mul16.sv
src/mul32.sv
src/mul64_simd.sv
src/lane_pack.sv
src/simd_mul_unit.sv
sim/tb_clock.sv
sim/tb_simd_mul.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
# The exit status is nonzero unless the run reports a pass.
cd "$(dirname "$0")" &&
verilator --binary --top-module tb_simd_mul -f files.f -Mdir obj_dir &&
./obj_dir/Vtb_simd_mul | tee /dev/stderr | grep -qF "=== PASS ===" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
